// ==== common/tcdm_macros.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// TCDM subsystem sizing
// Widths, bank geometry and credit counts
// ~~~~~~~~~~~~~~~~~~~~
`ifndef TCDM_MACROS_SVH
`define TCDM_MACROS_SVH

`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define STRB_WIDTH (`DATA_WIDTH / 8)

// Word-interleaved banks
`define NR_TCDM   2
`define BANK_ROWS 256

// Response credits, also the depth of each response FIFO
`define MAX_OUTSTANDING_READS 2

// Request credits granted by a bank after reset
`define BANK_CREDITS 2

`endif

// ==== common/tcdm_addr_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// TCDM address package
// Region rule, credit counter and the two views of an address
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "tcdm_macros.svh"

package tcdm_addr_pkg;

  localparam int unsigned OFFSET_BITS = $clog2(`STRB_WIDTH);
  localparam int unsigned BANK_BITS   = $clog2(`NR_TCDM);
  localparam int unsigned ROW_BITS    = $clog2(`BANK_ROWS);
  localparam int unsigned UPPER_BITS  = `ADDR_WIDTH - ROW_BITS - BANK_BITS - OFFSET_BITS;

  typedef logic [$clog2(`BANK_CREDITS + 1)-1:0] credit_t;

  // End address is exclusive
  typedef struct packed {
    logic [`ADDR_WIDTH-1:0] start_addr;
    logic [`ADDR_WIDTH-1:0] end_addr;
  } address_map_t;

  typedef struct packed {
    logic [UPPER_BITS-1:0]  upper;
    logic [ROW_BITS-1:0]    row;
    logic [BANK_BITS-1:0]   bank;
    logic [OFFSET_BITS-1:0] offset;
  } addr_fields_t;

  // Demux compares the flat word, banks index by row
  typedef union packed {
    logic [`ADDR_WIDTH-1:0] flat;
    addr_fields_t           fields;
  } tcdm_addr_u;

endpackage

`default_nettype wire

// ==== common/tcdm_req_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// TCDM request package
// Request and response payloads of the core, SoC and bank ports
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "tcdm_macros.svh"

package tcdm_req_pkg;

  typedef struct packed {
    tcdm_addr_pkg::tcdm_addr_u addr;
    logic                      write;
    logic [`DATA_WIDTH-1:0]    data;
    logic [`STRB_WIDTH-1:0]    strb;
  } dreq_t;

  // Only reads produce one of these
  typedef struct packed {
    logic [`DATA_WIDTH-1:0] data;
    logic                   error;
  } dresp_t;

endpackage

`default_nettype wire

// ==== verilog/resp_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Bank response FIFO
// Fall-through storage for read data returned by one bank
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "tcdm_macros.svh"

module resp_fifo #(
  parameter int unsigned WIDTH = `DATA_WIDTH,
  parameter int unsigned DEPTH = `MAX_OUTSTANDING_READS
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             push_i,
  output logic [WIDTH-1:0] data_o,
  input  logic             pop_i,
  output logic             empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             stored_empty;
  logic             push_store;
  logic             pop_store;

  assign stored_empty = (count_q == '0);

  // Pushed word shows up at the output in the same cycle
  assign data_o  = stored_empty ? data_i : mem_q[rd_ptr_q];
  assign empty_o = stored_empty & ~push_i;

  // A word pushed and popped while empty never gets stored
  assign push_store = push_i & ~(stored_empty & pop_i);
  assign pop_store  = pop_i & ~stored_empty;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_store) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_store) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (PTR_W + 1)'(push_store) - (PTR_W + 1)'(pop_store);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_store) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== tcdm_shim/addr_demux.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Address demux
// Routes core requests, returns read responses in issue order
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "tcdm_macros.svh"

module addr_demux (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  tcdm_req_pkg::dreq_t                 req_i,
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  output tcdm_req_pkg::dresp_t                resp_o,
  output logic                                resp_valid_o,
  input  logic                                resp_ready_i,
  output tcdm_req_pkg::dreq_t  [`NR_TCDM:0]   port_req_o,
  output logic [`NR_TCDM:0]                   port_valid_o,
  input  logic [`NR_TCDM:0]                   port_ready_i,
  input  tcdm_req_pkg::dresp_t [`NR_TCDM:0]   port_resp_i,
  input  logic [`NR_TCDM:0]                   port_resp_valid_i,
  output logic [`NR_TCDM:0]                   port_resp_ready_o,
  input  tcdm_addr_pkg::address_map_t         address_map_i
);

  localparam int unsigned NR_PORTS    = `NR_TCDM + 1;
  localparam int unsigned SEL_W       = $clog2(NR_PORTS);
  localparam int unsigned QUEUE_DEPTH = NR_PORTS;
  localparam int unsigned QPTR_W      = $clog2(QUEUE_DEPTH);

  logic [SEL_W-1:0]  order_q [QUEUE_DEPTH];
  logic [QPTR_W-1:0] rd_ptr_q;
  logic [QPTR_W-1:0] wr_ptr_q;
  logic [QPTR_W:0]   count_q;
  logic [SEL_W-1:0]  sel;
  logic [SEL_W-1:0]  head;
  logic              in_region;
  logic              order_full;
  logic              order_empty;
  logic              stall;
  logic              push;
  logic              pop;

  assign in_region = (req_i.addr.flat >= address_map_i.start_addr) &
                     (req_i.addr.flat <  address_map_i.end_addr);

  // Inside the region the interleave bit picks the bank
  assign sel = in_region ? SEL_W'(req_i.addr.fields.bank) : SEL_W'(`NR_TCDM);

  assign order_full  = (count_q == QUEUE_DEPTH);
  assign order_empty = (count_q == '0);

  // Reads wait for room in the order queue, writes pass
  assign stall = ~req_i.write & order_full;

  assign port_req_o = {NR_PORTS{req_i}};

  always_comb begin
    port_valid_o      = '0;
    port_valid_o[sel] = req_valid_i & ~stall;
  end

  assign req_ready_o = port_ready_i[sel] & ~stall;
  assign push        = req_valid_i & req_ready_o & ~req_i.write;

  // Only the oldest outstanding read may answer
  assign head         = order_q[rd_ptr_q];
  assign resp_o       = port_resp_i[head];
  assign resp_valid_o = ~order_empty & port_resp_valid_i[head];
  assign pop          = resp_valid_o & resp_ready_i;

  always_comb begin
    port_resp_ready_o       = '0;
    port_resp_ready_o[head] = resp_ready_i & ~order_empty;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (QPTR_W + 1)'(push) - (QPTR_W + 1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      order_q[wr_ptr_q] <= sel;
    end
  end

endmodule

`default_nettype wire

// ==== tcdm_shim/tcdm_shim.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// TCDM shim
// Core valid/ready to bank credit signalling, plus SoC port
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "tcdm_macros.svh"

module tcdm_shim (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  // Core
  input  tcdm_req_pkg::dreq_t                   data_q_i,
  input  logic                                  data_qvalid_i,
  output logic                                  data_qready_o,
  output tcdm_req_pkg::dresp_t                  data_p_o,
  output logic                                  data_pvalid_o,
  input  logic                                  data_pready_i,
  // SoC
  output tcdm_req_pkg::dreq_t                   soc_q_o,
  output logic                                  soc_qvalid_o,
  input  logic                                  soc_qready_i,
  input  tcdm_req_pkg::dresp_t                  soc_p_i,
  input  logic                                  soc_pvalid_i,
  output logic                                  soc_pready_o,
  input  tcdm_addr_pkg::address_map_t           address_map_i,
  // Banks
  output tcdm_req_pkg::dreq_t [`NR_TCDM-1:0]    tcdm_req_o,
  output logic [`NR_TCDM-1:0]                   tcdm_req_valid_o,
  input  logic [`NR_TCDM-1:0]                   tcdm_req_ready_i,
  input  logic [`NR_TCDM-1:0]                   tcdm_resp_valid_i,
  input  logic [`NR_TCDM-1:0][`DATA_WIDTH-1:0]  tcdm_resp_rdata_i,
  output logic [`NR_TCDM-1:0]                   tcdm_resp_ready_o
);

  import tcdm_addr_pkg::*;
  import tcdm_req_pkg::*;

  localparam int unsigned NR_PORTS      = `NR_TCDM + 1;
  localparam int unsigned RESP_CREDIT_W = $clog2(`MAX_OUTSTANDING_READS + 1);

  dreq_t  [NR_PORTS-1:0] port_req;
  logic   [NR_PORTS-1:0] port_valid;
  logic   [NR_PORTS-1:0] port_ready;
  dresp_t [NR_PORTS-1:0] port_resp;
  logic   [NR_PORTS-1:0] port_resp_valid;
  logic   [NR_PORTS-1:0] port_resp_ready;

  for (genvar i = 0; i < `NR_TCDM; i++) begin : gen_bank
    credit_t                  req_credits_q;
    credit_t                  req_credits_d;
    logic [RESP_CREDIT_W-1:0] resp_credits_q;
    logic [RESP_CREDIT_W-1:0] resp_credits_d;
    logic [`DATA_WIDTH-1:0]   fifo_data;
    logic                     fifo_empty;
    logic                     fifo_pop;

    // Request credits, one pulse in and one valid out each
    always_comb begin
      req_credits_d = req_credits_q;
      if (tcdm_req_ready_i[i]) begin
        req_credits_d = req_credits_d + 1'b1;
      end
      if (tcdm_req_valid_o[i]) begin
        req_credits_d = req_credits_d - 1'b1;
      end
    end

    assign port_ready[i]       = (req_credits_q != '0);
    assign tcdm_req_valid_o[i] = port_valid[i] & port_ready[i];
    assign tcdm_req_o[i]       = port_req[i];

    // Response credits track free FIFO slots
    always_comb begin
      resp_credits_d = resp_credits_q;
      if (tcdm_resp_valid_i[i]) begin
        resp_credits_d = resp_credits_d - 1'b1;
      end
      if (fifo_pop) begin
        resp_credits_d = resp_credits_d + 1'b1;
      end
    end

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        req_credits_q        <= '0;
        resp_credits_q       <= RESP_CREDIT_W'(`MAX_OUTSTANDING_READS);
        tcdm_resp_ready_o[i] <= 1'b0;
      end else begin
        req_credits_q        <= req_credits_d;
        resp_credits_q       <= resp_credits_d;
        tcdm_resp_ready_o[i] <= (resp_credits_d != '0);
      end
    end

    resp_fifo i_resp_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .data_i  (tcdm_resp_rdata_i[i]),
      .push_i  (tcdm_resp_valid_i[i]),
      .data_o  (fifo_data),
      .pop_i   (fifo_pop),
      .empty_o (fifo_empty)
    );

    assign port_resp[i]       = '{data: fifo_data, error: 1'b0};
    assign port_resp_valid[i] = ~fifo_empty;
    assign fifo_pop           = port_resp_valid[i] & port_resp_ready[i];
  end

  // SoC sits on the last demux port
  assign soc_q_o                   = port_req[`NR_TCDM];
  assign soc_qvalid_o              = port_valid[`NR_TCDM];
  assign port_ready[`NR_TCDM]      = soc_qready_i;
  assign port_resp[`NR_TCDM]       = soc_p_i;
  assign port_resp_valid[`NR_TCDM] = soc_pvalid_i;
  assign soc_pready_o              = port_resp_ready[`NR_TCDM];

  addr_demux i_addr_demux (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .req_i             (data_q_i),
    .req_valid_i       (data_qvalid_i),
    .req_ready_o       (data_qready_o),
    .resp_o            (data_p_o),
    .resp_valid_o      (data_pvalid_o),
    .resp_ready_i      (data_pready_i),
    .port_req_o        (port_req),
    .port_valid_o      (port_valid),
    .port_ready_i      (port_ready),
    .port_resp_i       (port_resp),
    .port_resp_valid_i (port_resp_valid),
    .port_resp_ready_o (port_resp_ready),
    .address_map_i     (address_map_i)
  );

endmodule

`default_nettype wire

// ==== verilog/tcdm_bank.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// TCDM bank
// SRAM with byte writes, held read data and credit return
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "tcdm_macros.svh"

module tcdm_bank (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  tcdm_req_pkg::dreq_t    req_i,
  input  logic                   req_valid_i,
  output logic                   credit_o,
  output logic                   resp_valid_o,
  output logic [`DATA_WIDTH-1:0] resp_rdata_o,
  input  logic                   resp_ready_i
);

  import tcdm_addr_pkg::*;

  localparam int unsigned HOLD_PTR_W = (`BANK_CREDITS > 1) ? $clog2(`BANK_CREDITS) : 1;

  logic [`DATA_WIDTH-1:0] mem_q  [`BANK_ROWS];
  logic [`DATA_WIDTH-1:0] hold_q [`BANK_CREDITS];
  logic [HOLD_PTR_W-1:0]  hold_rd_q;
  logic [HOLD_PTR_W-1:0]  hold_wr_q;
  credit_t                hold_cnt_q;
  credit_t                pend_q;
  logic [ROW_BITS-1:0]    row;
  logic                   rd_accept;
  logic                   wr_accept;
  logic                   held;
  logic                   delivered;

  assign row       = req_i.addr.fields.row;
  assign rd_accept = req_valid_i & ~req_i.write;
  assign wr_accept = req_valid_i & req_i.write;

  // Read results wait here until the shim has room
  assign held         = (hold_cnt_q != '0);
  assign delivered    = held & resp_ready_i;
  assign resp_valid_o = delivered;
  assign resp_rdata_o = hold_q[hold_rd_q];

  // Credits owed to the shim go out one per cycle
  assign credit_o = (pend_q != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hold_rd_q  <= '0;
      hold_wr_q  <= '0;
      hold_cnt_q <= '0;
      pend_q     <= credit_t'(`BANK_CREDITS);
    end else begin
      if (rd_accept) begin
        hold_wr_q <= (hold_wr_q == HOLD_PTR_W'(`BANK_CREDITS - 1)) ? '0 : hold_wr_q + 1'b1;
      end
      if (delivered) begin
        hold_rd_q <= (hold_rd_q == HOLD_PTR_W'(`BANK_CREDITS - 1)) ? '0 : hold_rd_q + 1'b1;
      end
      hold_cnt_q <= hold_cnt_q + credit_t'(rd_accept) - credit_t'(delivered);
      pend_q     <= pend_q + credit_t'(wr_accept) + credit_t'(delivered) - credit_t'(credit_o);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      hold_q[hold_wr_q] <= mem_q[row];
    end
    if (wr_accept) begin
      for (int b = 0; b < `STRB_WIDTH; b++) begin
        if (req_i.strb[b]) begin
          mem_q[row][8*b +: 8] <= req_i.data[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tcdm_subsys_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// TCDM subsystem top
// Shim with two interleaved banks and an external SoC port
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "tcdm_macros.svh"

module tcdm_subsys_top (
  input  logic                        clk_i,
  input  logic                        rst_i,
  // Core
  input  tcdm_req_pkg::dreq_t         data_q_i,
  input  logic                        data_qvalid_i,
  output logic                        data_qready_o,
  output tcdm_req_pkg::dresp_t        data_p_o,
  output logic                        data_pvalid_o,
  input  logic                        data_pready_i,
  // SoC
  output tcdm_req_pkg::dreq_t         soc_q_o,
  output logic                        soc_qvalid_o,
  input  logic                        soc_qready_i,
  input  tcdm_req_pkg::dresp_t        soc_p_i,
  input  logic                        soc_pvalid_i,
  output logic                        soc_pready_o,
  input  tcdm_addr_pkg::address_map_t address_map_i
);

  import tcdm_req_pkg::*;

  dreq_t [`NR_TCDM-1:0]                 tcdm_req;
  logic  [`NR_TCDM-1:0]                 tcdm_req_valid;
  logic  [`NR_TCDM-1:0]                 tcdm_credit;
  logic  [`NR_TCDM-1:0]                 tcdm_resp_valid;
  logic  [`NR_TCDM-1:0][`DATA_WIDTH-1:0] tcdm_resp_rdata;
  logic  [`NR_TCDM-1:0]                 tcdm_resp_ready;

  tcdm_shim i_tcdm_shim (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .data_q_i          (data_q_i),
    .data_qvalid_i     (data_qvalid_i),
    .data_qready_o     (data_qready_o),
    .data_p_o          (data_p_o),
    .data_pvalid_o     (data_pvalid_o),
    .data_pready_i     (data_pready_i),
    .soc_q_o           (soc_q_o),
    .soc_qvalid_o      (soc_qvalid_o),
    .soc_qready_i      (soc_qready_i),
    .soc_p_i           (soc_p_i),
    .soc_pvalid_i      (soc_pvalid_i),
    .soc_pready_o      (soc_pready_o),
    .address_map_i     (address_map_i),
    .tcdm_req_o        (tcdm_req),
    .tcdm_req_valid_o  (tcdm_req_valid),
    .tcdm_req_ready_i  (tcdm_credit),
    .tcdm_resp_valid_i (tcdm_resp_valid),
    .tcdm_resp_rdata_i (tcdm_resp_rdata),
    .tcdm_resp_ready_o (tcdm_resp_ready)
  );

  for (genvar i = 0; i < `NR_TCDM; i++) begin : gen_bank
    tcdm_bank i_tcdm_bank (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_i        (tcdm_req[i]),
      .req_valid_i  (tcdm_req_valid[i]),
      .credit_o     (tcdm_credit[i]),
      .resp_valid_o (tcdm_resp_valid[i]),
      .resp_rdata_o (tcdm_resp_rdata[i]),
      .resp_ready_i (tcdm_resp_ready[i])
    );
  end

endmodule

`default_nettype wire

// ==== tb/tcdm_subsys_assert.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Shim assertions
// Credit and handshake rules, bound to tcdm_shim
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "tcdm_macros.svh"

module tcdm_subsys_assert (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic [`NR_TCDM-1:0]  tcdm_req_valid_o,
  input logic [`NR_TCDM-1:0]  tcdm_req_ready_i,
  input logic [`NR_TCDM-1:0]  tcdm_resp_valid_i,
  input logic [`NR_TCDM-1:0]  tcdm_resp_ready_o,
  input tcdm_req_pkg::dresp_t data_p_o,
  input logic                 data_pvalid_o,
  input logic                 data_pready_i
);

  for (genvar i = 0; i < `NR_TCDM; i++) begin : gen_bank
    logic [3:0] credits_q;

    // Shadow of the request credits held by the shim
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        credits_q <= '0;
      end else begin
        credits_q <= credits_q + 4'(tcdm_req_ready_i[i]) - 4'(tcdm_req_valid_o[i]);
      end
    end

    a_valid_has_credit: assert property (@(posedge clk_i) disable iff (rst_i)
      tcdm_req_valid_o[i] |-> (credits_q != '0))
      else $error("Bank request valid without a credit");

    a_resp_when_ready: assert property (@(posedge clk_i) disable iff (rst_i)
      tcdm_resp_valid_i[i] |-> tcdm_resp_ready_o[i])
      else $error("Bank response while response ready is low");
  end

  a_resp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (data_pvalid_o && !data_pready_i) |=> (data_pvalid_o && $stable(data_p_o)))
    else $error("Core response changed while stalled");

  // Synchronous reset takes effect one edge later
  a_no_resp_in_reset: assert property (@(posedge clk_i) rst_i |=> !data_pvalid_o)
    else $error("Core response valid during reset");

endmodule

bind tcdm_shim tcdm_subsys_assert i_tcdm_subsys_assert (
  .clk_i             (clk_i),
  .rst_i             (rst_i),
  .tcdm_req_valid_o  (tcdm_req_valid_o),
  .tcdm_req_ready_i  (tcdm_req_ready_i),
  .tcdm_resp_valid_i (tcdm_resp_valid_i),
  .tcdm_resp_ready_o (tcdm_resp_ready_o),
  .data_p_o          (data_p_o),
  .data_pvalid_o     (data_pvalid_o),
  .data_pready_i     (data_pready_i)
);

`default_nettype wire

// ==== tb/tcdm_subsys_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// TCDM subsystem testbench
// Directed tests with a SoC responder and a reference memory
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "tcdm_macros.svh"

module tcdm_subsys_tb;

  import tcdm_addr_pkg::*;
  import tcdm_req_pkg::*;

  localparam int          CLK_PERIOD = 40;
  localparam int          TIMEOUT    = 200;
  localparam logic [31:0] TCDM_END   = 32'h0000_0800;
  localparam logic [31:0] SOC_BASE   = 32'h8000_0000;
  localparam logic [31:0] ERR_BASE   = 32'hF000_0000;
  localparam logic [31:0] ERR_END    = 32'hF000_1000;

  logic         clk_i;
  logic         rst_i;
  dreq_t        data_q_i;
  logic         data_qvalid_i;
  logic         data_qready_o;
  dresp_t       data_p_o;
  logic         data_pvalid_o;
  logic         data_pready_i;
  dreq_t        soc_q_o;
  logic         soc_qvalid_o;
  logic         soc_qready_i;
  dresp_t       soc_p_i;
  logic         soc_pvalid_i;
  logic         soc_pready_o;
  address_map_t address_map_i;

  // Both banks as one word array, indexed by {row, bank}
  logic [31:0] model [2*`BANK_ROWS];
  logic [31:0] exp_data_q [$];
  logic        exp_err_q [$];
  logic [31:0] soc_addr_q [$];
  int          soc_due_q [$];
  int          soc_delay;
  int          soc_cycle;
  dreq_t       last_soc_req;
  int          resp_count;
  int          checks;
  int          errors;
  int          timeouts;
  integer      seed;

  tcdm_subsys_top UUT (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .data_q_i      (data_q_i),
    .data_qvalid_i (data_qvalid_i),
    .data_qready_o (data_qready_o),
    .data_p_o      (data_p_o),
    .data_pvalid_o (data_pvalid_o),
    .data_pready_i (data_pready_i),
    .soc_q_o       (soc_q_o),
    .soc_qvalid_o  (soc_qvalid_o),
    .soc_qready_i  (soc_qready_i),
    .soc_p_i       (soc_p_i),
    .soc_pvalid_i  (soc_pvalid_i),
    .soc_pready_o  (soc_pready_o),
    .address_map_i (address_map_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  function automatic logic in_tcdm(input logic [31:0] addr);
    return (addr < TCDM_END);
  endfunction

  function automatic logic [31:0] soc_word(input logic [31:0] addr);
    return addr ^ 32'h5A5A_C3C3;
  endfunction

  function automatic logic soc_error(input logic [31:0] addr);
    return (addr >= ERR_BASE) && (addr < ERR_END);
  endfunction

  task automatic finish_run;
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout while waiting for %s at %0t ns", what, $time);
    finish_run();
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Presents one core request and waits for its handshake
  task automatic core_req(input logic [31:0] addr, input logic wr,
                          input logic [31:0] data, input logic [3:0] strb);
    int   cycles;
    logic done;
    int   idx;
    cycles = 0;
    done   = 1'b0;
    idx    = addr[10:2];
    data_q_i.addr.flat = addr;
    data_q_i.write     = wr;
    data_q_i.data      = data;
    data_q_i.strb      = strb;
    data_qvalid_i      = 1'b1;
    while (!done) begin
      #(CLK_PERIOD/4);
      if (data_qready_o) begin
        done = 1'b1;
        if (wr && in_tcdm(addr)) begin
          for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
              model[idx][8*b +: 8] = data[8*b +: 8];
            end
          end
        end else if (!wr) begin
          exp_data_q.push_back(in_tcdm(addr) ? model[idx] : soc_word(addr));
          exp_err_q.push_back(in_tcdm(addr) ? 1'b0 : soc_error(addr));
        end
      end
      @(negedge clk_i);
      cycles++;
      if (!done && cycles > TIMEOUT) begin
        report_timeout("core request acceptance");
      end
    end
    data_qvalid_i = 1'b0;
  endtask

  task automatic wait_drain;
    int cycles;
    cycles = 0;
    while (exp_data_q.size() != 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_timeout("outstanding read responses");
      end
    end
  endtask

  // Answers SoC reads in order, soc_delay cycles after acceptance
  task automatic soc_responder;
    forever begin
      @(negedge clk_i);
      soc_cycle++;
      if (soc_addr_q.size() > 0 && soc_due_q[0] <= soc_cycle) begin
        soc_p_i.data  = soc_word(soc_addr_q[0]);
        soc_p_i.error = soc_error(soc_addr_q[0]);
        soc_pvalid_i  = 1'b1;
      end else begin
        soc_p_i      = '0;
        soc_pvalid_i = 1'b0;
      end
      #(CLK_PERIOD/4);
      if (soc_pvalid_i && soc_pready_o) begin
        void'(soc_addr_q.pop_front());
        void'(soc_due_q.pop_front());
      end
      if (soc_qvalid_o && soc_qready_i) begin
        last_soc_req = soc_q_o;
        if (!soc_q_o.write) begin
          soc_addr_q.push_back(soc_q_o.addr.flat);
          soc_due_q.push_back(soc_cycle + 1 + soc_delay);
        end
      end
    end
  endtask

  initial begin
    soc_responder();
  end

  // Core response monitor, compares in issue order
  initial begin
    forever begin
      @(negedge clk_i);
      #(CLK_PERIOD/4);
      if (data_pvalid_o && data_pready_i) begin
        checks++;
        assert (exp_data_q.size() != 0) else begin
          errors++;
          $display("Core response at %0t ns with no read outstanding", $time);
        end
        if (exp_data_q.size() != 0) begin
          check_value("read data", data_p_o.data, exp_data_q.pop_front());
          check_value("read error", data_p_o.error, exp_err_q.pop_front());
          resp_count++;
        end
      end
    end
  end

  task automatic test_reset;
    repeat (4) begin
      @(negedge clk_i);
      #(CLK_PERIOD/4);
      check_value("data_pvalid_o in reset", data_pvalid_o, 1'b0);
      check_value("soc_qvalid_o in reset", soc_qvalid_o, 1'b0);
    end
    @(negedge clk_i);
    rst_i = 1'b0;
    #(CLK_PERIOD/4);
    check_value("data_qready_o before credits", data_qready_o, 1'b0);
    check_value("data_pvalid_o after reset", data_pvalid_o, 1'b0);
    check_value("soc_qvalid_o after reset", soc_qvalid_o, 1'b0);
    repeat (4) @(negedge clk_i);
  endtask

  task automatic test_tcdm_rw;
    core_req(32'h0000_0010, 1'b1, 32'h1122_3344, 4'hF);
    core_req(32'h0000_0014, 1'b1, 32'h5566_7788, 4'hF);
    core_req(32'h0000_0010, 1'b1, 32'hAABB_CCDD, 4'b0101);
    core_req(32'h0000_0014, 1'b1, 32'h99EE_FF00, 4'b1010);
    core_req(32'h0000_0010, 1'b0, 32'h0, 4'h0);
    core_req(32'h0000_0014, 1'b0, 32'h0, 4'h0);
    wait_drain();
  endtask

  task automatic test_soc;
    soc_delay = 2;
    core_req(SOC_BASE + 32'h40, 1'b1, 32'hCAFE_0123, 4'b0011);
    check_value("soc_q_o address", last_soc_req.addr.flat, SOC_BASE + 32'h40);
    check_value("soc_q_o write", last_soc_req.write, 1'b1);
    check_value("soc_q_o data", last_soc_req.data, 32'hCAFE_0123);
    check_value("soc_q_o strobe", last_soc_req.strb, 4'b0011);
    core_req(SOC_BASE + 32'h44, 1'b0, 32'h0, 4'h0);
    core_req(ERR_BASE + 32'h08, 1'b0, 32'h0, 4'h0);
    wait_drain();
    soc_delay = 1;
  endtask

  task automatic test_order;
    int start;
    start     = resp_count;
    soc_delay = 6;
    core_req(32'h0000_0010, 1'b0, 32'h0, 4'h0);
    core_req(SOC_BASE + 32'h100, 1'b0, 32'h0, 4'h0);
    core_req(32'h0000_0014, 1'b0, 32'h0, 4'h0);
    wait_drain();
    check_value("ordered response count", resp_count - start, 3);
    soc_delay = 1;
  endtask

  // Three reads to bank 0 fill its FIFO and leave one held in the bank
  task automatic test_backpressure;
    int start;
    start         = resp_count;
    data_pready_i = 1'b0;
    core_req(32'h0000_0018, 1'b1, 32'h0F1E_2D3C, 4'hF);
    core_req(32'h0000_0020, 1'b1, 32'h4B5A_6978, 4'hF);
    core_req(32'h0000_0010, 1'b0, 32'h0, 4'h0);
    core_req(32'h0000_0018, 1'b0, 32'h0, 4'h0);
    core_req(32'h0000_0020, 1'b0, 32'h0, 4'h0);
    repeat (8) @(negedge clk_i);
    check_value("responses while stalled", resp_count - start, 0);
    data_pready_i = 1'b1;
    wait_drain();
    check_value("responses after release", resp_count - start, 3);
  endtask

  task automatic test_random;
    logic [31:0] r;
    logic [31:0] addr;
    for (int i = 0; i < 32; i++) begin
      core_req(32'(i * 4), 1'b1, $random(seed), 4'hF);
    end
    for (int n = 0; n < 200; n++) begin
      r = $random(seed);
      if (r[1:0] != 2'd3) begin
        addr = {25'd0, r[6:2], 2'b00};
      end else if (r[8]) begin
        addr = ERR_BASE + {26'd0, r[7:2], 2'b00};
      end else begin
        addr = SOC_BASE + {18'd0, r[13:2], 2'b00};
      end
      core_req(addr, r[16], $random(seed), r[20:17]);
    end
    wait_drain();
  endtask

  initial begin
    seed          = 49;
    checks        = 0;
    errors        = 0;
    timeouts      = 0;
    resp_count    = 0;
    soc_cycle     = 0;
    soc_delay     = 1;
    rst_i         = 1'b1;
    data_q_i      = '0;
    data_qvalid_i = 1'b0;
    data_pready_i = 1'b1;
    soc_qready_i  = 1'b1;
    soc_p_i       = '0;
    soc_pvalid_i  = 1'b0;
    address_map_i = '{start_addr: 32'h0, end_addr: TCDM_END};
    test_reset();
    test_tcdm_rw();
    test_soc();
    test_order();
    test_backpressure();
    test_random();
    finish_run();
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/tcdm_addr_pkg.sv
common/tcdm_req_pkg.sv
verilog/resp_fifo.sv
tcdm_shim/addr_demux.sv
tcdm_shim/tcdm_shim.sv
verilog/tcdm_bank.sv
verilog/tcdm_subsys_top.sv
tb/tcdm_subsys_assert.sv
tb/tcdm_subsys_tb.sv
